/* ex_stage.f */
hdl/ex_pkg.sv
hdl/ex_operand_select.sv
hdl/ex_alu.sv
hdl/ex_branch.sv
hdl/ex_multiplier.sv
hdl/ex_complete_arbiter.sv
hdl/ex_stage.sv
verification/ex_stage_assert.sv
verification/ex_stage_checker.sv
verification/ex_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the execute stage testbench with Verilator and run it.
# The result is read from sim.log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module ex_stage_tb \
  -f ex_stage.f --Mdir obj_dir

./obj_dir/Vex_stage_tb > sim.log 2>&1
cat sim.log

if grep -q "Some tests failed" sim.log; then
  exit 1
fi
exit 0

/* verification/ex_stage_tb.sv */
/* Testbench top for the execute stage. Drives LFSR based issue traffic and
   flushes into the DUT, while the checker module compares the completions. */

`timescale 1ns/1ps

module ex_stage_tb
  import ex_pkg::*;
();

  logic             clock;
  logic             rst_n;
  logic             flush;
  issue_pkt_t       issue_pkt;
  complete_pkt_t    complete_pkt;
  fu_mask_t         free;
  int               chk_errors;
  int               chk_checks;
  int               chk_pending;

  logic [15:0]      lfsr_q;
  fu_mask_t         busy;
  logic [tag_w-1:0] next_tag;
  int               tb_errors;
  int               issued;
  int               err_base;
  int               issued_base;
  int               total_errors;

  // Test lengths, the watchdog budget follows from them
  int alu_ops           = 60;
  int branch_ops        = 40;
  int mult_ops          = 30;
  int contention_rounds = 10;
  int mix_cycles        = 200;
  int flush_rounds      = 12;

  always #10 clock = ~clock;

  ex_stage dut_i (
    .clock        (clock),
    .rst_n        (rst_n),
    .flush        (flush),
    .issue_pkt    (issue_pkt),
    .complete_pkt (complete_pkt),
    .free         (free)
  );

  ex_stage_checker chk_i (
    .clock         (clock),
    .rst_n         (rst_n),
    .flush         (flush),
    .issue_pkt     (issue_pkt),
    .complete_pkt  (complete_pkt),
    .error_count   (chk_errors),
    .check_count   (chk_checks),
    .pending_count (chk_pending)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Random numbers
  ////////////////////////////////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // Small values now and then so shifts and equal compares get exercised
  function automatic logic [xlen-1:0] rand_operand();
    if (rand_bits(2) == 0) begin
      return rand_bits(5);
    end
    return rand_bits(32);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Issue side
  ////////////////////////////////////////////////////////////////////////////

  // Inputs change 2 ns after the edge, free is read there too
  task automatic next_cycle();
    @(posedge clock);
    #2;
    busy      = busy & ~free;
    issue_pkt = '0;
    flush     = 1'b0;
  endtask

  task automatic issue_op(input fu_e fu);
    issue_pkt_t  p;
    logic [31:0] r;
    p               = '0;
    p.valid         = 1'b1;
    p.fu            = fu;
    p.opa_sel       = opa_sel_e'(2'(rand_bits(2) % 3));
    p.opb_sel       = opb_sel_e'(1'(rand_bits(1)));
    p.alu_op        = alu_op_e'(4'(rand_bits(4) % 10));
    p.mult_op       = mult_op_e'(1'(rand_bits(1)));
    p.br_cond       = br_cond_e'(3'(rand_bits(3) % 6));
    p.uncond_branch = (rand_bits(2) == 0);
    p.cond_branch   = !p.uncond_branch;
    p.pc            = rand_bits(30) << 2;
    p.rs1_value     = rand_operand();
    p.rs2_value     = (rand_bits(2) == 0) ? p.rs1_value : rand_operand();
    r               = rand_bits(12);
    p.imm           = {{20{r[11]}}, r[11:0]};
    p.tag           = next_tag;
    p.dest_reg      = 6'(rand_bits(6));
    p.has_dest      = 1'(rand_bits(1));
    issue_pkt       = p;
    busy[fu]        = 1'b1;
    next_tag++;
    issued++;
  endtask

  task automatic try_issue(input fu_e fu);
    if (!busy[fu]) begin
      issue_op(fu);
    end
  endtask

  // Three of four picks issue, the rest leave a bubble
  task automatic pick_and_issue();
    logic [1:0] pick;
    pick = 2'(rand_bits(2));
    if (pick != 2'd3) begin
      try_issue(fu_e'(pick));
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy != '0 && n < 50) begin
      next_cycle();
      n++;
    end
    if (busy != '0) begin
      $display("ERROR time=%0t: units %b were never freed", $time, busy);
      tb_errors++;
      busy = '0;
    end
    // Last completion is sampled by the checker at the next edge
    next_cycle();
  endtask

  task automatic run_solo(input fu_e fu, input int count);
    repeat (count) begin
      issue_op(fu);
      next_cycle();
      wait_idle();
    end
  endtask

  // ALU and branch results land in the slots together with a multiply
  task automatic run_contention();
    repeat (contention_rounds) begin
      try_issue(fu_mult);
      next_cycle();
      next_cycle();
      try_issue(fu_alu);
      next_cycle();
      try_issue(fu_branch);
      next_cycle();
      try_issue(fu_alu);
      next_cycle();
      wait_idle();
    end
    repeat (mix_cycles) begin
      pick_and_issue();
      next_cycle();
    end
    wait_idle();
  endtask

  task automatic run_flush();
    repeat (flush_rounds) begin
      repeat (3 + rand_bits(3)) begin
        pick_and_issue();
        next_cycle();
      end
      flush = 1'b1;
      busy  = '0;
      next_cycle();
      repeat (6) begin
        pick_and_issue();
        next_cycle();
      end
      wait_idle();
    end
  endtask

  task automatic report_test(input string name);
    $display("test %-12s issued %4d  errors %0d", name, issued - issued_base,
             chk_errors + tb_errors - err_base);
    err_base    = chk_errors + tb_errors;
    issued_base = issued;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clock       = 1'b0;
    rst_n       = 1'b0;
    flush       = 1'b0;
    issue_pkt   = '0;
    lfsr_q      = 16'd1155;
    busy        = '0;
    next_tag    = '0;
    tb_errors   = 0;
    issued      = 0;
    err_base    = 0;
    issued_base = 0;
    repeat (3) next_cycle();
    rst_n = 1'b1;
    next_cycle();

    run_solo(fu_alu, alu_ops);
    report_test("alu_ops");
    run_solo(fu_branch, branch_ops);
    report_test("branches");
    run_solo(fu_mult, mult_ops);
    report_test("multiplies");
    run_contention();
    report_test("contention");
    run_flush();
    report_test("flush");

    if (chk_pending != 0) begin
      $display("ERROR time=%0t: %0d issued results never completed", $time, chk_pending);
      tb_errors++;
    end
    total_errors = chk_errors + tb_errors;
    $display("Summary: 5 tests, %0d issued, %0d completions checked, %0d errors",
             issued, chk_checks, total_errors);
    if (total_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // About ten cycles per solo op, generous for the mixed phases
  initial begin
    int budget;
    budget = 20 + (alu_ops + branch_ops + mult_ops) * 10 + contention_rounds * 20
             + mix_cycles + 60 + flush_rounds * 40 + 200;
    #(budget * 20);
    $display("ERROR time=%0t: watchdog expired after %0d cycles", $time, budget);
    $display("Some tests failed");
    $finish;
  end

endmodule

/* verification/ex_stage_checker.sv */
/* Reference model and scoreboard for the execute stage. Expected results are
   stored by tag at issue and compared whenever complete_pkt is valid. */

`timescale 1ns/1ps

module ex_stage_checker
  import ex_pkg::*;
(
  input  logic          clock,
  input  logic          rst_n,
  input  logic          flush,
  input  issue_pkt_t    issue_pkt,
  input  complete_pkt_t complete_pkt,
  output int            error_count,
  output int            check_count,
  output int            pending_count
);

  complete_pkt_t expected [2**tag_w];
  logic          live     [2**tag_w];
  logic          solo     [2**tag_w];
  int            issue_at [2**tag_w];
  int            slot_at  [2**tag_w];
  int            edge_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // Model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [xlen-1:0] operand_a(input issue_pkt_t p);
    if (p.opa_sel == opa_rs1) begin
      return p.rs1_value;
    end
    if (p.opa_sel == opa_pc) begin
      return p.pc;
    end
    return '0;
  endfunction

  function automatic logic [xlen-1:0] operand_b(input issue_pkt_t p);
    return (p.opb_sel == opb_imm) ? p.imm : p.rs2_value;
  endfunction

  function automatic logic [xlen-1:0] alu_model(input alu_op_e op,
                                                input logic [xlen-1:0] a,
                                                input logic [xlen-1:0] b);
    logic [4:0] s;
    s = b[4:0];
    case (op)
      alu_add:  return a + b;
      alu_sub:  return a + ~b + 32'd1;
      alu_and:  return a & b;
      alu_or:   return a | b;
      alu_xor:  return a ^ b;
      alu_sll:  return a << s;
      alu_srl:  return a >> s;
      // Fill the vacated high bits with the sign
      alu_sra:  return (a >> s) | (a[xlen-1] ? ~({xlen{1'b1}} >> s) : '0);
      alu_slt:  return {{(xlen-1){1'b0}}, (a[xlen-1] != b[xlen-1]) ? a[xlen-1] : (a < b)};
      alu_sltu: return {{(xlen-1){1'b0}}, a < b};
      default:  return '0;
    endcase
  endfunction

  // Shift and add, one partial product per bit of b
  function automatic logic [xlen-1:0] mult_model(input mult_op_e op,
                                                 input logic [xlen-1:0] a,
                                                 input logic [xlen-1:0] b);
    logic [2*xlen-1:0] p;
    logic [2*xlen-1:0] a_wide;
    p      = '0;
    a_wide = {{xlen{1'b0}}, a};
    for (int i = 0; i < xlen; i++) begin
      if (b[i]) begin
        p = p + (a_wide << i);
      end
    end
    return (op == mult_mulhu) ? p[2*xlen-1:xlen] : p[xlen-1:0];
  endfunction

  function automatic logic branch_taken(input issue_pkt_t p);
    logic eq;
    logic lt_u;
    logic lt_s;
    logic hit;
    eq   = (p.rs1_value == p.rs2_value);
    lt_u = (p.rs1_value < p.rs2_value);
    lt_s = (p.rs1_value[xlen-1] != p.rs2_value[xlen-1]) ? p.rs1_value[xlen-1] : lt_u;
    case (p.br_cond)
      br_beq:  hit = eq;
      br_bne:  hit = !eq;
      br_blt:  hit = lt_s;
      br_bge:  hit = !lt_s;
      br_bltu: hit = lt_u;
      br_bgeu: hit = !lt_u;
      default: hit = 1'b0;
    endcase
    return p.uncond_branch || (p.cond_branch && hit);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Scoreboard
  ////////////////////////////////////////////////////////////////////////////

  task automatic compare(input string name, input logic [xlen-1:0] exp_v,
                         input logic [xlen-1:0] got_v);
    if (exp_v !== got_v) begin
      $display("MISMATCH time=%0t %s expected=%h actual=%h (tag %0d)",
               $time, name, exp_v, got_v, complete_pkt.tag);
      error_count++;
    end
  endtask

  task automatic drop_all();
    for (int u = 0; u < 2**tag_w; u++) begin
      live[u] = 1'b0;
      solo[u] = 1'b0;
    end
    pending_count = 0;
  endtask

  task automatic record_issue();
    logic [tag_w-1:0] t;
    logic [xlen-1:0]  a;
    logic [xlen-1:0]  b;
    t = issue_pkt.tag;
    a = operand_a(issue_pkt);
    b = operand_b(issue_pkt);
    if (live[t]) begin
      $display("ERROR time=%0t: tag %0d issued again while in flight", $time, t);
      error_count++;
    end
    // Exact latency holds only with nothing else in flight
    for (int u = 0; u < 2**tag_w; u++) begin
      solo[u] = 1'b0;
    end
    solo[t]                 = (pending_count == 0);
    expected[t]             = '0;
    expected[t].valid       = 1'b1;
    expected[t].fu          = issue_pkt.fu;
    expected[t].tag         = t;
    expected[t].dest_reg    = issue_pkt.dest_reg;
    expected[t].has_dest    = issue_pkt.has_dest;
    case (issue_pkt.fu)
      fu_alu: begin
        expected[t].result = alu_model(issue_pkt.alu_op, a, b);
      end
      fu_mult: begin
        expected[t].result = mult_model(issue_pkt.mult_op, a, b);
      end
      default: begin
        expected[t].result      = a + b;
        expected[t].take_branch = branch_taken(issue_pkt);
      end
    endcase
    live[t]     = 1'b1;
    issue_at[t] = edge_cnt;
    slot_at[t]  = (issue_pkt.fu == fu_mult) ? edge_cnt + mult_stages - 1 : edge_cnt;
    pending_count++;
  endtask

  task automatic check_completion();
    logic [tag_w-1:0] t;
    int               lat;
    int               min_lat;
    t = complete_pkt.tag;
    check_count++;
    if (!live[t]) begin
      $display("ERROR time=%0t: tag %0d completed but was not in flight", $time, t);
      error_count++;
    end else begin
      compare("complete_pkt.fu", xlen'(expected[t].fu), xlen'(complete_pkt.fu));
      compare("complete_pkt.result", expected[t].result, complete_pkt.result);
      compare("complete_pkt.take_branch", xlen'(expected[t].take_branch),
              xlen'(complete_pkt.take_branch));
      compare("complete_pkt.dest_reg", xlen'(expected[t].dest_reg),
              xlen'(complete_pkt.dest_reg));
      compare("complete_pkt.has_dest", xlen'(expected[t].has_dest),
              xlen'(complete_pkt.has_dest));
      lat     = edge_cnt - issue_at[t];
      min_lat = (expected[t].fu == fu_mult) ? mult_stages + 1 : 2;
      if (lat < min_lat || (solo[t] && lat != min_lat)) begin
        $display("ERROR time=%0t: tag %0d completed after %0d cycles, expected %0d",
                 $time, t, lat, min_lat);
        error_count++;
      end
      // Selected one edge ago, so anything slotted before that edge with
      // higher priority should have gone first
      for (int u = 0; u < 2**tag_w; u++) begin
        if (live[u] && u != int'(t) && expected[u].fu < expected[t].fu &&
            slot_at[u] <= edge_cnt - 2) begin
          $display("ERROR time=%0t: tag %0d completed ahead of higher priority tag %0d",
                   $time, t, u);
          error_count++;
        end
      end
      live[t] = 1'b0;
      pending_count--;
    end
  endtask

  // DUT outputs and driven inputs are both stable at the edge
  always @(posedge clock) begin
    if (!rst_n) begin
      drop_all();
    end else begin
      if (complete_pkt.valid) begin
        check_completion();
      end
      if (flush) begin
        drop_all();
      end else if (issue_pkt.valid) begin
        record_issue();
      end
    end
    edge_cnt++;
  end

endmodule

/* verification/ex_stage_assert.sv */
/* Concurrent checks on the completion arbiter outputs.
   Attached to ex_complete_arbiter by the bind at the end of this file. */

`timescale 1ns/1ps

module ex_stage_assert
  import ex_pkg::*;
(
  input logic          clock,
  input logic          rst_n,
  input logic          flush,
  input complete_pkt_t complete_pkt,
  input fu_mask_t      free
);

  // One unit freed per cycle at most
  free_onehot_a: assert property (@(posedge clock) disable iff (!rst_n)
    $onehot0(free))
    else $error("free has more than one bit set: %b", free);

  // Free pulse belongs to the completing unit
  free_matches_fu_a: assert property (@(posedge clock) disable iff (!rst_n)
    complete_pkt.valid |-> (free == (fu_mask_t'(1) << complete_pkt.fu)))
    else $error("free %b does not match completing unit %0d", free, complete_pkt.fu);

  quiet_after_flush_a: assert property (@(posedge clock) disable iff (!rst_n)
    flush |=> (!complete_pkt.valid && (free == '0)))
    else $error("completion or free pulse in the cycle after a flush");

endmodule

bind ex_complete_arbiter ex_stage_assert assert_i (
  .clock        (clock),
  .rst_n        (rst_n),
  .flush        (flush),
  .complete_pkt (complete_pkt),
  .free         (free)
);

/* hdl/ex_stage.sv */
/* Execute stage top: operand select, ALU, branch unit and multiplier,
   merged onto one completion port by the arbiter. */

`timescale 1ns/1ps

module ex_stage
  import ex_pkg::*;
(
  input  logic          clock,
  input  logic          rst_n,
  input  logic          flush,
  input  issue_pkt_t    issue_pkt,
  output complete_pkt_t complete_pkt,
  output fu_mask_t      free
);

  logic [xlen-1:0] opa;
  logic [xlen-1:0] opb;
  unit_out_t       alu_out;
  unit_out_t       branch_out;
  unit_out_t       mult_out;

  ex_operand_select operand_select_i (
    .issue_pkt (issue_pkt),
    .opa       (opa),
    .opb       (opb)
  );

  ex_alu alu_i (
    .issue_pkt (issue_pkt),
    .opa       (opa),
    .opb       (opb),
    .alu_out   (alu_out)
  );

  ex_branch branch_i (
    .issue_pkt  (issue_pkt),
    .opa        (opa),
    .opb        (opb),
    .branch_out (branch_out)
  );

  // Only unit that holds in-flight state besides the slots
  ex_multiplier multiplier_i (
    .clock     (clock),
    .rst_n     (rst_n),
    .flush     (flush),
    .issue_pkt (issue_pkt),
    .opa       (opa),
    .opb       (opb),
    .mult_out  (mult_out)
  );

  ex_complete_arbiter complete_arbiter_i (
    .clock        (clock),
    .rst_n        (rst_n),
    .flush        (flush),
    .alu_out      (alu_out),
    .mult_out     (mult_out),
    .branch_out   (branch_out),
    .complete_pkt (complete_pkt),
    .free         (free)
  );

endmodule

/* hdl/ex_complete_arbiter.sv */
/* Completion slots for each unit and the fixed-priority pick that sends one
   result per cycle to commit, with a matching free pulse. */

`timescale 1ns/1ps

module ex_complete_arbiter
  import ex_pkg::*;
(
  input  logic          clock,
  input  logic          rst_n,
  input  logic          flush,
  input  unit_out_t     alu_out,
  input  unit_out_t     mult_out,
  input  unit_out_t     branch_out,
  output complete_pkt_t complete_pkt,
  output fu_mask_t      free
);

  unit_out_t unit_in [num_fu];
  unit_out_t slot_q  [num_fu];
  fu_mask_t  slot_valid;
  fu_mask_t  done_mask;
  fu_mask_t  grant;
  fu_e       sel_fu;
  logic      out_valid;
  fu_e       out_fu;
  unit_out_t out_data;

  assign unit_in[fu_alu]    = alu_out;
  assign unit_in[fu_mult]   = mult_out;
  assign unit_in[fu_branch] = branch_out;

  always_comb begin
    for (int i = 0; i < num_fu; i++) begin
      done_mask[i] = unit_in[i].done;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Fixed priority, lowest fu_e wins
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    grant  = '0;
    sel_fu = fu_alu;
    for (int i = num_fu - 1; i >= 0; i--) begin
      if (slot_valid[i]) begin
        grant  = fu_mask_t'(1) << i;
        sel_fu = fu_e'(i);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control state
  ////////////////////////////////////////////////////////////////////////////

  // A new done refills a slot even when it is drained at the same edge
  always_ff @(posedge clock) begin
    if (!rst_n || flush) begin
      slot_valid <= '0;
      out_valid  <= 1'b0;
      free       <= '0;
    end else begin
      slot_valid <= (slot_valid & ~grant) | done_mask;
      out_valid  <= |grant;
      free       <= grant;
    end
  end

  // Slot contents and output payload
  always_ff @(posedge clock) begin
    for (int i = 0; i < num_fu; i++) begin
      if (unit_in[i].done) begin
        slot_q[i] <= unit_in[i];
      end
    end
    out_fu   <= sel_fu;
    out_data <= slot_q[sel_fu];
  end

  assign complete_pkt = '{
    valid:       out_valid,
    fu:          out_fu,
    result:      out_data.result,
    take_branch: out_data.take_branch,
    tag:         out_data.tag,
    dest_reg:    out_data.dest_reg,
    has_dest:    out_data.has_dest
  };

endmodule

/* hdl/ex_multiplier.sv */
/* Fixed-depth unsigned multiplier. The full product and the packet fields
   ride through the pipeline; the last stage picks the low or high word. */

`timescale 1ns/1ps

module ex_multiplier
  import ex_pkg::*;
(
  input  logic            clock,
  input  logic            rst_n,
  input  logic            flush,
  input  issue_pkt_t      issue_pkt,
  input  logic [xlen-1:0] opa,
  input  logic [xlen-1:0] opb,
  output unit_out_t       mult_out
);

  typedef struct packed {
    mult_op_e             op;
    logic [2*xlen-1:0]    product;
    logic [tag_w-1:0]     tag;
    logic [reg_idx_w-1:0] dest_reg;
    logic                 has_dest;
  } mult_stage_t;

  logic                 start;
  logic [2*xlen-1:0]    product;
  logic [mult_regs-1:0] valid_q;
  mult_stage_t          stage_q [mult_regs];
  mult_stage_t          last;

  assign start   = issue_pkt.valid && (issue_pkt.fu == fu_mult);
  assign product = {{xlen{1'b0}}, opa} * {{xlen{1'b0}}, opb};

  // Valid chain, cleared on flush
  always_ff @(posedge clock) begin
    if (!rst_n || flush) begin
      valid_q <= '0;
    end else begin
      for (int i = mult_regs - 1; i > 0; i--) begin
        valid_q[i] <= valid_q[i-1];
      end
      valid_q[0] <= start;
    end
  end

  // Payload shifts every cycle
  always_ff @(posedge clock) begin
    stage_q[0].op       <= issue_pkt.mult_op;
    stage_q[0].product  <= product;
    stage_q[0].tag      <= issue_pkt.tag;
    stage_q[0].dest_reg <= issue_pkt.dest_reg;
    stage_q[0].has_dest <= issue_pkt.has_dest;
    for (int i = 1; i < mult_regs; i++) begin
      stage_q[i] <= stage_q[i-1];
    end
  end

  assign last = stage_q[mult_regs-1];

  always_comb begin
    mult_out.done        = valid_q[mult_regs-1];
    mult_out.result      = (last.op == mult_mulhu) ? last.product[2*xlen-1:xlen]
                                                   : last.product[xlen-1:0];
    mult_out.take_branch = 1'b0;
    mult_out.tag         = last.tag;
    mult_out.dest_reg    = last.dest_reg;
    mult_out.has_dest    = last.has_dest;
  end

endmodule

/* hdl/ex_branch.sv */
/* Branch unit: target adder plus condition check on rs1/rs2.
   Combinational, done in the issue cycle. */

`timescale 1ns/1ps

module ex_branch
  import ex_pkg::*;
(
  input  issue_pkt_t      issue_pkt,
  input  logic [xlen-1:0] opa,
  input  logic [xlen-1:0] opb,
  output unit_out_t       branch_out
);

  logic [xlen-1:0] rs1;
  logic [xlen-1:0] rs2;
  logic            cond_true;

  assign rs1 = issue_pkt.rs1_value;
  assign rs2 = issue_pkt.rs2_value;

  // Condition compares register values, not the selected operands
  always_comb begin
    case (issue_pkt.br_cond)
      br_beq:  cond_true = (rs1 == rs2);
      br_bne:  cond_true = (rs1 != rs2);
      br_blt:  cond_true = ($signed(rs1) < $signed(rs2));
      br_bge:  cond_true = ($signed(rs1) >= $signed(rs2));
      br_bltu: cond_true = (rs1 < rs2);
      br_bgeu: cond_true = (rs1 >= rs2);
      default: cond_true = 1'b0;
    endcase
  end

  always_comb begin
    branch_out.done        = issue_pkt.valid && (issue_pkt.fu == fu_branch);
    branch_out.result      = opa + opb;
    branch_out.take_branch = issue_pkt.uncond_branch ||
                             (issue_pkt.cond_branch && cond_true);
    branch_out.tag         = issue_pkt.tag;
    branch_out.dest_reg    = issue_pkt.dest_reg;
    branch_out.has_dest    = issue_pkt.has_dest;
  end

endmodule

/* hdl/ex_alu.sv */
/* Single-cycle integer ALU. Result and done are combinational
   in the issue cycle and are captured by the completion arbiter. */

`timescale 1ns/1ps

module ex_alu
  import ex_pkg::*;
(
  input  issue_pkt_t      issue_pkt,
  input  logic [xlen-1:0] opa,
  input  logic [xlen-1:0] opb,
  output unit_out_t       alu_out
);

  logic [4:0]      shamt;
  logic [xlen-1:0] result;

  // Only the low five bits shift
  assign shamt = opb[4:0];

  always_comb begin
    case (issue_pkt.alu_op)
      alu_add:  result = opa + opb;
      alu_sub:  result = opa - opb;
      alu_and:  result = opa & opb;
      alu_or:   result = opa | opb;
      alu_xor:  result = opa ^ opb;
      alu_sll:  result = opa << shamt;
      alu_srl:  result = opa >> shamt;
      alu_sra:  result = $signed(opa) >>> shamt;
      alu_slt: begin
        result = {{(xlen-1){1'b0}}, $signed(opa) < $signed(opb)};
      end
      alu_sltu: begin
        result = {{(xlen-1){1'b0}}, opa < opb};
      end
      default:  result = '0;
    endcase
  end

  always_comb begin
    alu_out.done        = issue_pkt.valid && (issue_pkt.fu == fu_alu);
    alu_out.result      = result;
    alu_out.take_branch = 1'b0;
    alu_out.tag         = issue_pkt.tag;
    alu_out.dest_reg    = issue_pkt.dest_reg;
    alu_out.has_dest    = issue_pkt.has_dest;
  end

endmodule

/* hdl/ex_operand_select.sv */
/* Operand multiplexers feeding all functional units.
   Operand A from rs1, PC or zero; operand B from rs2 or the immediate. */

`timescale 1ns/1ps

module ex_operand_select
  import ex_pkg::*;
(
  input  issue_pkt_t      issue_pkt,
  output logic [xlen-1:0] opa,
  output logic [xlen-1:0] opb
);

  // Operand A
  always_comb begin
    case (issue_pkt.opa_sel)
      opa_rs1: begin
        opa = issue_pkt.rs1_value;
      end
      opa_pc: begin
        opa = issue_pkt.pc;
      end
      opa_zero: begin
        opa = '0;
      end
      default: begin
        opa = '0;
      end
    endcase
  end

  // Operand B
  always_comb begin
    case (issue_pkt.opb_sel)
      opb_rs2: begin
        opb = issue_pkt.rs2_value;
      end
      opb_imm: begin
        opb = issue_pkt.imm;
      end
      default: begin
        opb = '0;
      end
    endcase
  end

endmodule

/* hdl/ex_pkg.sv */
/* Shared widths, encodings and packet types for the execute stage.
   Imported by every RTL block and by the testbench. */

package ex_pkg;

  localparam int xlen        = 32;
  localparam int tag_w       = 5;
  localparam int reg_idx_w   = 6;
  localparam int mult_stages = 4;
  // Issue cycle forms the product, the rest are pipeline registers
  localparam int mult_regs   = mult_stages - 1;
  localparam int num_fu      = 3;

  ////////////////////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////////////////////

  // Order is arbiter priority and free bit position
  typedef enum logic [1:0] {fu_alu, fu_mult, fu_branch} fu_e;

  typedef enum logic [1:0] {opa_rs1, opa_pc, opa_zero} opa_sel_e;

  typedef enum logic {opb_rs2, opb_imm} opb_sel_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor,
    alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu
  } alu_op_e;

  typedef enum logic {mult_mul, mult_mulhu} mult_op_e;

  typedef enum logic [2:0] {br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu} br_cond_e;

  typedef logic [num_fu-1:0] fu_mask_t;

  ////////////////////////////////////////////////////////////////////////////
  // Packets
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                 valid;
    fu_e                  fu;
    opa_sel_e             opa_sel;
    opb_sel_e             opb_sel;
    alu_op_e              alu_op;
    mult_op_e             mult_op;
    br_cond_e             br_cond;
    logic                 cond_branch;
    logic                 uncond_branch;
    logic [xlen-1:0]      pc;
    logic [xlen-1:0]      rs1_value;
    logic [xlen-1:0]      rs2_value;
    logic [xlen-1:0]      imm;   // already sign extended
    logic [tag_w-1:0]     tag;
    logic [reg_idx_w-1:0] dest_reg;
    logic                 has_dest;
  } issue_pkt_t;

  typedef struct packed {
    logic                 done;
    logic [xlen-1:0]      result;
    logic                 take_branch;
    logic [tag_w-1:0]     tag;
    logic [reg_idx_w-1:0] dest_reg;
    logic                 has_dest;
  } unit_out_t;

  typedef struct packed {
    logic                 valid;
    fu_e                  fu;
    logic [xlen-1:0]      result;
    logic                 take_branch;
    logic [tag_w-1:0]     tag;
    logic [reg_idx_w-1:0] dest_reg;
    logic                 has_dest;
  } complete_pkt_t;

endpackage
